/* hdl/la_defs.svh */
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// Register port
`define LA_ADDR_WIDTH        8
`define LA_DATA_WIDTH        8
`define LA_BYTECNT_WIDTH     2    // Byte index into multibyte fields

// Capture sizing
`define LA_DEPTH_WIDTH       16
`define LA_DOWNSAMPLE_WIDTH  16
`define LA_PROBES            9
`define LA_WORD_WIDTH        (2 * `LA_PROBES)   // Two samples per probe

// Trigger and arm synchronizer depth
`define LA_SYNC_STAGES       2

// Probe 0 is the LSB, alternating from a one
`define LA_DEFAULT_PATTERN   9'b1_0101_0101

// Register map
`define LA_CAPTURE_GROUP     8'h00
`define LA_ENABLED           8'h01   // Enable bit, status on read
`define LA_TRIGGER_SOURCE    8'h02
`define LA_CAPTURE_DEPTH     8'h03   // Two bytes
`define LA_MANUAL_CAPTURE    8'h04
`define LA_DOWNSAMPLE        8'h05   // Two bytes
`define LA_ARM               8'h06   // Cleared by hardware at capture start

`endif

/* hdl/la_pkg.sv */
`default_nettype none

package la_pkg;

   // Values 4 to 7 fall through to the default pattern
   typedef enum logic [2:0] {
      group_io     = 3'd0,
      group_userio = 3'd1,
      group_debug  = 3'd2,
      group_trace  = 3'd3
   } probe_group_t;

   // Upper two bits of the trigger source register
   typedef enum logic [1:0] {
      trig_none   = 2'd0,
      trig_io     = 2'd1,
      trig_userio = 2'd2,
      trig_debug  = 2'd3
   } trigger_kind_t;

   typedef enum logic {
      st_idle      = 1'b0,
      st_capturing = 1'b1
   } capture_state_t;

endpackage

`default_nettype wire

/* hdl/la_regs.sv */
`default_nettype none
`include "la_defs.svh"

module la_regs (
   input  logic                             observer_clk,
   input  logic                             reset,
   input  logic [`LA_ADDR_WIDTH-1:0]        reg_address,
   input  logic [`LA_BYTECNT_WIDTH-1:0]     reg_bytecnt,
   input  logic [`LA_DATA_WIDTH-1:0]        reg_datai,
   input  logic                             reg_write,
   input  logic                             reg_read,
   input  logic                             capturing,
   input  logic                             capture_go,
   output logic [`LA_DATA_WIDTH-1:0]        reg_datao,
   output la_pkg::trigger_kind_t            trigger_kind,
   output logic                             trigger_invert,
   output logic [2:0]                       trigger_index,
   output logic                             manual_capture,
   output la_pkg::probe_group_t             capture_group,
   output logic [`LA_DEPTH_WIDTH-1:0]       capture_depth,
   output logic [`LA_DOWNSAMPLE_WIDTH-1:0]  downsample,
   output logic                             arm
);
   import la_pkg::*;

   logic reg_enabled;

   // Byte 0 is the low byte, other indices read as zero
   function automatic logic [`LA_DATA_WIDTH-1:0] get_byte(input logic [15:0] value,
                                                          input logic [1:0] idx);
      case (idx)
         2'd0:    get_byte = value[7:0];
         2'd1:    get_byte = value[15:8];
         default: get_byte = '0;
      endcase
   endfunction

   function automatic logic [15:0] set_byte(input logic [15:0] value,
                                            input logic [1:0] idx,
                                            input logic [7:0] data);
      set_byte = value;
      case (idx)
         2'd0:    set_byte[7:0] = data;
         2'd1:    set_byte[15:8] = data;
         default: ;   // Out of range byte is ignored
      endcase
   endfunction

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trigger_kind   <= trig_none;
         trigger_invert <= 1'b0;
         trigger_index  <= 3'd0;
         manual_capture <= 1'b0;
         capture_group  <= group_io;
         capture_depth  <= '0;
         downsample     <= '0;
         reg_enabled    <= 1'b0;
         arm            <= 1'b0;
      end else begin
         if (reg_write) begin
            case (reg_address)
               `LA_CAPTURE_GROUP: capture_group <= probe_group_t'(reg_datai[2:0]);
               `LA_ENABLED:       reg_enabled <= reg_datai[0];
               `LA_TRIGGER_SOURCE: begin
                  trigger_kind   <= trigger_kind_t'(reg_datai[5:4]);
                  trigger_invert <= reg_datai[3];
                  trigger_index  <= reg_datai[2:0];
               end
               `LA_CAPTURE_DEPTH:  capture_depth <= set_byte(capture_depth, reg_bytecnt, reg_datai);
               `LA_MANUAL_CAPTURE: manual_capture <= reg_datai[0];
               `LA_DOWNSAMPLE:     downsample <= set_byte(downsample, reg_bytecnt, reg_datai);
               default: ;
            endcase
         end

         // A write in the same cycle wins over the auto-clear
         if (reg_write && (reg_address == `LA_ARM))
            arm <= reg_datai[0];
         else if (capture_go)
            arm <= 1'b0;
      end
   end

   always_comb begin
      reg_datao = '0;
      if (reg_read) begin
         case (reg_address)
            `LA_CAPTURE_GROUP:  reg_datao = {5'b0, capture_group};
            `LA_ENABLED:        reg_datao = {6'b0, capturing, reg_enabled};
            `LA_TRIGGER_SOURCE: reg_datao = {2'b0, trigger_kind, trigger_invert, trigger_index};
            `LA_CAPTURE_DEPTH:  reg_datao = get_byte(capture_depth, reg_bytecnt);
            `LA_MANUAL_CAPTURE: reg_datao = {7'b0, manual_capture};
            `LA_DOWNSAMPLE:     reg_datao = get_byte(downsample, reg_bytecnt);
            `LA_ARM:            reg_datao = {7'b0, arm};
            default:            reg_datao = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/la_trigger_select.sv */
`default_nettype none
`include "la_defs.svh"

module la_trigger_select (
   input  la_pkg::trigger_kind_t     trigger_kind,
   input  logic                      trigger_invert,
   input  logic [2:0]                trigger_index,
   input  logic                      manual_capture,
   input  logic [`LA_PROBES-1:0]     io_probes,
   input  logic [`LA_PROBES-1:0]     userio_probes,
   input  logic [`LA_PROBES-1:0]     debug_probes,
   output logic                      trigger_level
);
   import la_pkg::*;

   logic picked;

   // Only the low probes of each group can trigger
   always_comb begin
      picked = 1'b0;
      case (trigger_kind)
         trig_none: begin
            picked = 1'b0;
         end
         trig_io: begin
            picked = io_probes[trigger_index[1:0]];      // io 0 to 3
         end
         trig_userio: begin
            picked = userio_probes[trigger_index];       // userio 0 to 7
         end
         trig_debug: begin
            picked = debug_probes[trigger_index[0]];     // debug 0 or 1
         end
      endcase
   end

   // Invert applies to the probe but not to manual capture
   assign trigger_level = (picked ^ trigger_invert) | manual_capture;

endmodule

`default_nettype wire

/* hdl/la_decimator.sv */
`default_nettype none
`include "la_defs.svh"

module la_decimator (
   input  logic                             observer_clk,
   input  logic                             reset,
   input  logic                             capture_go,
   input  logic [`LA_DOWNSAMPLE_WIDTH-1:0]  downsample,
   output logic                             tick
);

   logic [`LA_DOWNSAMPLE_WIDTH-1:0] count;

   // One tick every downsample+1 cycles, phase locked to capture start
   always_ff @(posedge observer_clk) begin
      if (reset || capture_go) begin
         count <= '0;
         tick  <= 1'b0;
      end else if (count == downsample) begin
         count <= '0;
         tick  <= 1'b1;
      end else begin
         count <= count + 1'b1;
         tick  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* hdl/la_probe_sampler.sv */
`default_nettype none
`include "la_defs.svh"

module la_probe_sampler (
   input  logic                        observer_clk,
   input  logic                        reset,
   input  la_pkg::probe_group_t        capture_group,
   input  logic                        sample_en,
   input  logic [`LA_PROBES-1:0]       io_probes,
   input  logic [`LA_PROBES-1:0]       userio_probes,
   input  logic [`LA_PROBES-1:0]       debug_probes,
   input  logic [`LA_PROBES-1:0]       trace_probes,
   output logic [`LA_WORD_WIDTH-1:0]   fifo_wr_data
);
   import la_pkg::*;

   logic [`LA_PROBES-1:0] group_sel;   // Registered group mux
   logic [`LA_PROBES-1:0] hist_new;
   logic [`LA_PROBES-1:0] hist_old;

   // Selected group is registered every cycle regardless of capture
   always_ff @(posedge observer_clk) begin
      case (capture_group)
         group_io: begin
            group_sel <= io_probes;
         end
         group_userio: begin
            group_sel <= userio_probes;
         end
         group_debug: begin
            group_sel <= debug_probes;
         end
         group_trace: begin
            group_sel <= trace_probes;
         end
         default: begin
            group_sel <= `LA_DEFAULT_PATTERN;
         end
      endcase
   end

   // Two-deep history per probe
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         hist_new <= '0;
         hist_old <= '0;
      end else if (sample_en) begin
         hist_old <= hist_new;
         hist_new <= group_sel;
      end
   end

   // Interleave so each probe owns an adjacent bit pair, older sample on top
   always_comb begin
      for (int k = 0; k < `LA_PROBES; k++) begin
         fifo_wr_data[2*k+1] = hist_old[k];
         fifo_wr_data[2*k]   = hist_new[k];
      end
   end

endmodule

`default_nettype wire

/* hdl/la_capture_ctrl.sv */
`default_nettype none
`include "la_defs.svh"

module la_capture_ctrl (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  logic                         trigger_level,
   input  logic                         arm,
   input  logic                         tick,
   input  logic [`LA_DEPTH_WIDTH-1:0]   capture_depth,
   output logic                         capture_go,
   output logic                         capturing,
   output logic                         sample_en,
   output logic                         fifo_wr
);
   import la_pkg::*;

   localparam int TRIG_BIT = 0;
   localparam int ARM_BIT  = 1;

   // Trigger and arm share one synchronizer and edge detector
   logic [`LA_SYNC_STAGES-1:0][1:0] sync_pipe;
   logic [1:0]                      sync_r;
   logic [1:0]                      sync_r2;
   logic [1:0]                      rise;

   logic                            armed;
   capture_state_t                  state;
   logic [`LA_DEPTH_WIDTH-1:0]      sample_count;
   logic [`LA_DEPTH_WIDTH-1:0]      depth_last;
   logic                            write_phase;   // High after odd samples

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_pipe <= '0;
         sync_r    <= '0;
         sync_r2   <= '0;
      end else begin
         sync_pipe <= {sync_pipe[`LA_SYNC_STAGES-2:0], {arm, trigger_level}};
         sync_r    <= sync_pipe[`LA_SYNC_STAGES-1];
         sync_r2   <= sync_r;
      end
   end

   assign rise       = sync_r & ~sync_r2;
   assign capturing  = (state == st_capturing);
   assign capture_go = rise[TRIG_BIT] & armed & ~capturing;
   assign sample_en  = capturing & tick;
   assign depth_last = capture_depth - 1'b1;

   // Armed drops as soon as a capture is running
   always_ff @(posedge observer_clk) begin
      if (reset)
         armed <= 1'b0;
      else if (capturing)
         armed <= 1'b0;
      else if (rise[ARM_BIT])
         armed <= 1'b1;
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state        <= st_idle;
         sample_count <= '0;
         write_phase  <= 1'b0;
         fifo_wr      <= 1'b0;
      end else if (capture_go) begin
         state        <= st_capturing;
         sample_count <= '0;
         write_phase  <= 1'b0;
         fifo_wr      <= 1'b0;
      end else if (sample_en) begin
         write_phase  <= ~write_phase;
         fifo_wr      <= write_phase;   // Every second sample completes a word
         sample_count <= sample_count + 1'b1;
         if (sample_count == depth_last)
            state <= st_idle;
      end else begin
         fifo_wr <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* hdl/logic_analyzer.sv */
`default_nettype none
`include "la_defs.svh"

module logic_analyzer (
   input  logic                          observer_clk,
   input  logic                          reset,
   input  logic [`LA_ADDR_WIDTH-1:0]     reg_address,
   input  logic [`LA_BYTECNT_WIDTH-1:0]  reg_bytecnt,
   input  logic [`LA_DATA_WIDTH-1:0]     reg_datai,
   input  logic                          reg_write,
   input  logic                          reg_read,
   input  logic [`LA_PROBES-1:0]         io_probes,
   input  logic [`LA_PROBES-1:0]         userio_probes,
   input  logic [`LA_PROBES-1:0]         debug_probes,
   input  logic [`LA_PROBES-1:0]         trace_probes,
   output logic [`LA_DATA_WIDTH-1:0]     reg_datao,
   output logic                          fifo_wr,
   output logic [`LA_WORD_WIDTH-1:0]     fifo_wr_data
);
   import la_pkg::*;

   // Configuration from the register file
   trigger_kind_t                    trigger_kind;
   logic                             trigger_invert;
   logic [2:0]                       trigger_index;
   logic                             manual_capture;
   probe_group_t                     capture_group;
   logic [`LA_DEPTH_WIDTH-1:0]       capture_depth;
   logic [`LA_DOWNSAMPLE_WIDTH-1:0]  downsample;
   logic                             arm;

   // Control and datapath
   logic trigger_level;
   logic capture_go;
   logic capturing;
   logic sample_en;
   logic tick;

   la_regs u_regs (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datai      (reg_datai),
      .reg_write      (reg_write),
      .reg_read       (reg_read),
      .capturing      (capturing),
      .capture_go     (capture_go),
      .reg_datao      (reg_datao),
      .trigger_kind   (trigger_kind),
      .trigger_invert (trigger_invert),
      .trigger_index  (trigger_index),
      .manual_capture (manual_capture),
      .capture_group  (capture_group),
      .capture_depth  (capture_depth),
      .downsample     (downsample),
      .arm            (arm)
   );

   la_trigger_select u_trigger_select (
      .trigger_kind   (trigger_kind),
      .trigger_invert (trigger_invert),
      .trigger_index  (trigger_index),
      .manual_capture (manual_capture),
      .io_probes      (io_probes),
      .userio_probes  (userio_probes),
      .debug_probes   (debug_probes),
      .trigger_level  (trigger_level)
   );

   la_capture_ctrl u_capture_ctrl (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .trigger_level  (trigger_level),
      .arm            (arm),
      .tick           (tick),
      .capture_depth  (capture_depth),
      .capture_go     (capture_go),
      .capturing      (capturing),
      .sample_en      (sample_en),
      .fifo_wr        (fifo_wr)
   );

   la_decimator u_decimator (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .capture_go     (capture_go),
      .downsample     (downsample),
      .tick           (tick)
   );

   la_probe_sampler u_probe_sampler (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .capture_group  (capture_group),
      .sample_en      (sample_en),
      .io_probes      (io_probes),
      .userio_probes  (userio_probes),
      .debug_probes   (debug_probes),
      .trace_probes   (trace_probes),
      .fifo_wr_data   (fifo_wr_data)
   );

endmodule

`default_nettype wire

/* test/la_properties.sv */
`default_nettype none

module la_properties (
   input  logic                   observer_clk,
   input  logic                   reset,
   input  logic                   fifo_wr,
   input  logic                   capture_go,
   input  logic                   capturing,
   input  logic                   sample_en,
   input  logic                   arm,
   input  la_pkg::capture_state_t state
);
   import la_pkg::*;

   // A word needs two samples, so strobes never touch
   assert property (@(posedge observer_clk) disable iff (reset) fifo_wr |=> !fifo_wr)
      else $error("fifo_wr high on two consecutive cycles");

   // Arm register still set and no capture running in the cycle before
   assert property (@(posedge observer_clk) disable iff (reset)
                    capture_go |-> arm && $past(state == st_idle))
      else $error("capture_go while not idle or not armed");

   // Decimator restarts with the capture so its first cycle never samples
   assert property (@(posedge observer_clk) disable iff (reset)
                    sample_en |-> $past(capturing))
      else $error("sample_en outside a capture");

endmodule

`default_nettype wire

/* test/la_checker.sv */
`default_nettype none
`include "la_defs.svh"

module la_checker (
   input  logic                       observer_clk,
   input  logic                       reset,
   input  logic                       fifo_wr,
   input  logic [`LA_WORD_WIDTH-1:0]  fifo_wr_data,
   input  logic [`LA_DATA_WIDTH-1:0]  reg_datao
);

   logic [`LA_WORD_WIDTH-1:0] exp_word;
   int exp_gap;
   int case_base;
   int value_errors;
   int word_errors;
   int value_checks;
   int word_checks;
   int total_writes;
   longint cycle;
   longint last_wr;

   initial begin
      exp_word = '0;
      exp_gap = 0;
      case_base = 0;
      value_errors = 0;
      value_checks = 0;
   end

   initial begin
      word_errors = 0;
      word_checks = 0;
      total_writes = 0;
      cycle = 0;
      last_wr = 0;
   end

   always @(posedge observer_clk) begin
      cycle = cycle + 1;
      if (!reset && fifo_wr) begin
         word_checks = word_checks + 1;
         if (fifo_wr_data !== exp_word) begin
            $display("Fail at %0t: fifo_wr_data expected %h actual %h",
                     $time, exp_word, fifo_wr_data);
            word_errors = word_errors + 1;
         end
         // Gap only measured between writes of the same capture
         if (total_writes > case_base && (cycle - last_wr) != exp_gap) begin
            $display("Fail at %0t: fifo_wr spacing expected %0d actual %0d",
                     $time, exp_gap, cycle - last_wr);
            word_errors = word_errors + 1;
         end
         last_wr = cycle;
         total_writes = total_writes + 1;
      end
   end

   task automatic start_case(input logic [`LA_WORD_WIDTH-1:0] word, input int gap);
      exp_word = word;
      exp_gap = gap;
      case_base = total_writes;
   endtask

   function automatic int case_writes();
      return total_writes - case_base;
   endfunction

   task automatic check_read(input string name, input logic [`LA_DATA_WIDTH-1:0] exp);
      value_checks = value_checks + 1;
      if (reg_datao !== exp) begin
         $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, reg_datao);
         value_errors = value_errors + 1;
      end
   endtask

   task automatic check_count(input int exp);
      value_checks = value_checks + 1;
      if (case_writes() != exp) begin
         $display("Fail at %0t: fifo_wr count expected %0d actual %0d",
                  $time, exp, case_writes());
         value_errors = value_errors + 1;
      end
   endtask

   function automatic int error_total();
      return value_errors + word_errors;
   endfunction

   task automatic report();
      $display("Checks %0d, words %0d, writes %0d, errors %0d",
               value_checks + word_checks, word_checks, total_writes, error_total());
   endtask

endmodule

`default_nettype wire

/* test/tb_logic_analyzer.sv */
`default_nettype none
`include "la_defs.svh"

module tb_logic_analyzer;
   import la_pkg::*;

   localparam int COLS = 13;
   localparam int MAX_CASES = 16;

   logic                          observer_clk = 1'b0;
   logic                          reset = 1'b1;
   logic [`LA_ADDR_WIDTH-1:0]     reg_address = '0;
   logic [`LA_BYTECNT_WIDTH-1:0]  reg_bytecnt = '0;
   logic [`LA_DATA_WIDTH-1:0]     reg_datai = '0;
   logic                          reg_write = 1'b0;
   logic                          reg_read = 1'b0;
   logic [`LA_PROBES-1:0]         io_probes = '0;
   logic [`LA_PROBES-1:0]         userio_probes = '0;
   logic [`LA_PROBES-1:0]         debug_probes = '0;
   logic [`LA_PROBES-1:0]         trace_probes = '0;
   logic [`LA_DATA_WIDTH-1:0]     reg_datao;
   logic                          fifo_wr;
   logic [`LA_WORD_WIDTH-1:0]     fifo_wr_data;

   logic [31:0] cases [0:COLS*MAX_CASES-1];
   int seed = 32'h1b2a_9733;

   always #20 observer_clk = ~observer_clk;

   logic_analyzer u_logic_analyzer (.*);

   la_checker u_checker (
      .observer_clk (observer_clk),
      .reset        (reset),
      .fifo_wr      (fifo_wr),
      .fifo_wr_data (fifo_wr_data),
      .reg_datao    (reg_datao)
   );

   bind la_capture_ctrl la_properties u_properties (
      .observer_clk (observer_clk),
      .reset        (reset),
      .fifo_wr      (fifo_wr),
      .capture_go   (capture_go),
      .capturing    (capturing),
      .sample_en    (sample_en),
      .arm          (arm),
      .state        (state)
   );

   // Each probe appears twice as the older and the newer sample
   function automatic logic [`LA_WORD_WIDTH-1:0] duplicate(input logic [`LA_PROBES-1:0] v);
      logic [`LA_WORD_WIDTH-1:0] w;
      for (int k = 0; k < `LA_PROBES; k++) begin
         w[2*k+1] = v[k];
         w[2*k]   = v[k];
      end
      return w;
   endfunction

   task automatic write_reg(input logic [7:0] addr, input logic [1:0] bc, input logic [7:0] d);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bc;
      reg_datai   <= d;
      reg_write   <= 1'b1;
      @(posedge observer_clk);
      reg_write   <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [1:0] bc, output logic [7:0] d);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bc;
      reg_read    <= 1'b1;
      @(negedge observer_clk);
      d = reg_datao;
   endtask

   task automatic read_check(input string name, input logic [7:0] addr, input logic [1:0] bc,
                             input logic [7:0] exp);
      logic [7:0] d;
      read_reg(addr, bc, d);
      u_checker.check_read(name, exp);
      @(posedge observer_clk);
      reg_read <= 1'b0;
   endtask

   task automatic run_case(input int n);
      logic [31:0] c [COLS];
      logic [`LA_PROBES-1:0] sel;
      logic [`LA_WORD_WIDTH-1:0] word;
      logic [7:0] status;
      for (int i = 0; i < COLS; i++)
         c[i] = cases[n*COLS+i];
      @(posedge observer_clk);
      reset <= 1'b1;
      repeat (2) @(posedge observer_clk);
      reset <= 1'b0;
      if (c[8][1])
         c[7] = 32'($random(seed));   // Random trace group
      io_probes     <= c[4][8:0];
      userio_probes <= c[5][8:0];
      debug_probes  <= c[6][8:0];
      trace_probes  <= c[7][8:0];
      write_reg(`LA_CAPTURE_GROUP, 2'd0, c[0][7:0]);
      write_reg(`LA_ENABLED, 2'd0, 8'h01);
      write_reg(`LA_CAPTURE_DEPTH, 2'd0, c[2][7:0]);
      write_reg(`LA_CAPTURE_DEPTH, 2'd1, c[2][15:8]);
      write_reg(`LA_DOWNSAMPLE, 2'd0, c[3][7:0]);
      write_reg(`LA_DOWNSAMPLE, 2'd1, c[3][15:8]);
      read_check("capture_group", `LA_CAPTURE_GROUP, 2'd0, {5'b0, c[0][2:0]});
      read_check("enabled", `LA_ENABLED, 2'd0, 8'h01);
      read_check("capture_depth[7:0]", `LA_CAPTURE_DEPTH, 2'd0, c[2][7:0]);
      read_check("capture_depth[15:8]", `LA_CAPTURE_DEPTH, 2'd1, c[2][15:8]);
      read_check("downsample[7:0]", `LA_DOWNSAMPLE, 2'd0, c[3][7:0]);
      read_check("downsample[15:8]", `LA_DOWNSAMPLE, 2'd1, c[3][15:8]);
      // Probe values after the raise, held for the whole capture
      case (c[9])
         1: c[4] = c[4] ^ c[10];
         2: c[5] = c[5] ^ c[10];
         3: c[6] = c[6] ^ c[10];
         default: ;
      endcase
      case (probe_group_t'(c[0][2:0]))
         group_io:     sel = c[4][8:0];
         group_userio: sel = c[5][8:0];
         group_debug:  sel = c[6][8:0];
         group_trace:  sel = c[7][8:0];
         default:      sel = `LA_DEFAULT_PATTERN;
      endcase
      word = c[8][1] ? duplicate(sel) : c[12][`LA_WORD_WIDTH-1:0];
      u_checker.start_case(word, 2 * (int'(c[3]) + 1));
      if (c[8][0]) begin
         write_reg(`LA_ARM, 2'd0, 8'h01);
         read_check("arm", `LA_ARM, 2'd0, 8'h01);
         repeat (8) @(posedge observer_clk);
      end
      write_reg(`LA_TRIGGER_SOURCE, 2'd0, c[1][7:0]);
      read_check("trigger_source", `LA_TRIGGER_SOURCE, 2'd0, {2'b0, c[1][5:0]});
      repeat (8) @(posedge observer_clk);
      io_probes     <= c[4][8:0];
      userio_probes <= c[5][8:0];
      debug_probes  <= c[6][8:0];
      if (c[9] == 4) begin
         write_reg(`LA_MANUAL_CAPTURE, 2'd0, 8'h01);
         read_check("manual_capture", `LA_MANUAL_CAPTURE, 2'd0, 8'h01);
      end
      if (c[11] == 0) begin
         repeat (4 * (int'(c[2]) * (int'(c[3]) + 1) + 40)) @(posedge observer_clk);
      end else begin
         while (u_checker.case_writes() < int'(c[11]))
            @(posedge observer_clk);
         read_check("arm", `LA_ARM, 2'd0, 8'h00);
         status = 8'h02;
         while (status[1]) begin
            read_reg(`LA_ENABLED, 2'd0, status);
            @(posedge observer_clk);
            reg_read <= 1'b0;
         end
         repeat (2 * (int'(c[3]) + 1) + 10) @(posedge observer_clk);
      end
      read_check("status", `LA_ENABLED, 2'd0, 8'h01);
      u_checker.check_count(int'(c[11]));
   endtask

   initial begin
      int ncases;
      longint budget;
      for (int i = 0; i < COLS*MAX_CASES; i++)
         cases[i] = 32'hffff_ffff;
      $readmemh("la_cases.txt", cases);
      ncases = 0;
      budget = 0;
      while (ncases < MAX_CASES && cases[ncases*COLS] != 32'hffff_ffff) begin
         budget += 4 * longint'(cases[ncases*COLS+2]) * (longint'(cases[ncases*COLS+3]) + 1);
         budget += 400;
         ncases++;
      end
      if (ncases == 0)
         $display("No test cases were read from la_cases.txt");
      fork
         begin
            #(budget * 40);
            $display("Watchdog timeout, the DUT stopped responding");
            $display("TEST FAIL");
            $finish;
         end
      join_none
      for (int n = 0; n < ncases; n++)
         run_case(n);
      u_checker.report();
      if (u_checker.error_total() == 0 && ncases > 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* la_cases.txt */
// grp src depth ds io userio debug trace flags(b0 arm,b1 random trace) raise_grp
// raise_mask count word (raise_grp 1 io, 2 userio, 3 debug, 4 manual; word ignored if random)
0 22 0008 0000 1a5 000 000 000 1 2 004 4 3cc33
5 11 0006 0002 000 000 000 000 1 1 002 3 33333
3 39 0005 0001 000 000 000 000 3 0 000 2 00000
1 10 0006 0000 000 0f0 000 000 0 1 001 0 00000
2 10 0006 0000 000 000 0aa 000 1 1 002 0 00000
2 00 0004 0003 000 000 0ff 000 1 4 000 2 0ffff
1 15 0007 0000 000 1ff 000 000 1 1 002 3 3ffff

/* logic_analyzer.f */
+incdir+hdl
hdl/la_pkg.sv
hdl/la_regs.sv
hdl/la_trigger_select.sv
hdl/la_decimator.sv
hdl/la_probe_sampler.sv
hdl/la_capture_ctrl.sv
hdl/logic_analyzer.sv
test/la_properties.sv
test/la_checker.sv
test/tb_logic_analyzer.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_logic_analyzer
RTL_TOP   = logic_analyzer
FILELIST  = logic_analyzer.f
BIN       = obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) | awk '{print} /^TEST PASS$$/{ok=1} END{exit !ok}'

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) +incdir+hdl hdl/la_pkg.sv \
		hdl/la_regs.sv hdl/la_trigger_select.sv hdl/la_decimator.sv \
		hdl/la_probe_sampler.sv hdl/la_capture_ctrl.sv hdl/logic_analyzer.sv

clean:
	rm -rf obj_dir
